//--- project.f
rtl/gemv_arith_pkg.sv
rtl/layerio_mem_pkg.sv
rtl/accel_ifs.sv
rtl/layerio_mem.sv
rtl/mem_arbiter.sv
rtl/host_port.sv
rtl/tile_fetch.sv
rtl/mxu.sv
rtl/quant_writeback.sv
rtl/gemv_top.sv
bench/gemv_sva.sv
bench/tb_gemv.sv

//--- Makefile
SIM      = verilator
TOP      = tb_gemv
FILELIST = project.f
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)

//--- bench/tb_gemv.sv
/*
 * GEMV tile engine testbench
 * directed tests against a shadow memory and a GEMV reference model
 */
`timescale 1ns/10ps

// 20 ns clock and an 8-cycle reset
module tb_clock (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
    end
endmodule

module tb_gemv;
    import gemv_arith_pkg::*;
    import layerio_mem_pkg::*;

    localparam int TIMEOUT = 2000;

    logic        clk;
    logic        rst_n;
    logic        host_wr;
    logic        host_rd;
    addr_t       host_addr;
    word_t       host_wdata;
    logic        host_ready;
    word_t       host_rdata;
    logic        host_rvalid;
    logic        start;
    addr_t       a_addr;
    addr_t       w_addr;
    addr_t       q_addr;
    tiles_m1_t   n_tiles_m1;
    shift_t      shift;
    logic        relu;
    logic        busy;
    logic        done;

    // mirror of every word written into the layerio memory
    word_t       shadow [MEM_DEPTH];
    logic [31:0] lfsr_state;
    int          done_count;

    tb_clock clock_u (.clk, .rst_n);

    gemv_top dut (
        .clk, .rst_n, .host_wr, .host_rd, .host_addr, .host_wdata,
        .host_ready, .host_rdata, .host_rvalid, .start, .a_addr, .w_addr,
        .q_addr, .n_tiles_m1, .shift, .relu, .busy, .done
    );

    // done pulses counted at mid-cycle
    always @(negedge clk) begin
        if (done) begin
            done_count = done_count + 1;
        end
    end

    // ======================================================================
    // helpers
    // ======================================================================
    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int b = 0; b < n; b++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h",
                                name, got, exp));
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic logic level_of(input string what);
        case (what)
            "host_ready":  return host_ready;
            "host_rvalid": return host_rvalid;
            "done":        return done;
            "busy":        return busy;
            default:       return !busy;
        endcase
    endfunction

    task automatic wait_for(input string what);
        int n;
        n = 0;
        while (!level_of(what)) begin
            if (n == TIMEOUT) begin
                abort_run($sformatf("timed out waiting for %s", what));
            end
            step();
            n++;
        end
    endtask

    task automatic host_write(input addr_t addr, input word_t data);
        wait_for("host_ready");
        host_wr    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        step();
        host_wr = 1'b0;
        shadow[addr] = data;
        // returns once the write has been granted
        wait_for("host_ready");
    endtask

    task automatic host_read(input addr_t addr, output word_t data);
        wait_for("host_ready");
        host_rd   = 1'b1;
        host_addr = addr;
        step();
        host_rd = 1'b0;
        wait_for("host_rvalid");
        data = host_rdata;
    endtask

    task automatic check_read(input addr_t addr);
        word_t got;
        host_read(addr, got);
        check("host_rdata", got, shadow[addr]);
    endtask

    // kind 0 small values in -4..3
    // kind 1 full int8 range
    // kind 2 only +127 or -128
    function automatic word_t make_vec(input int kind);
        word_t       v;
        logic [31:0] r;
        r = rand_bits(32);
        for (int i = 0; i < N_LANES; i++) begin
            case (kind)
                0:       v[ELEM_W*i +: ELEM_W] = {{5{r[ELEM_W*i+2]}}, r[ELEM_W*i +: 3]};
                1:       v[ELEM_W*i +: ELEM_W] = r[ELEM_W*i +: ELEM_W];
                default: v[ELEM_W*i +: ELEM_W] = r[ELEM_W*i] ? 8'h7f : 8'h80;
            endcase
        end
        return v;
    endfunction

    task automatic load_job(input addr_t a, input addr_t w, input tiles_m1_t ntm1,
                            input int kind);
        for (int k = 0; k <= int'(ntm1); k++) begin
            host_write(a + addr_t'(k), make_vec(kind));
            for (int j = 0; j < N_LANES; j++) begin
                host_write(w + addr_t'(N_LANES * k + j), make_vec(kind));
            end
        end
    endtask

    // ======================================================================
    // reference model over the shadow memory
    // ======================================================================
    function automatic word_t gemv_model(input addr_t a, input addr_t w,
                                         input tiles_m1_t ntm1, input shift_t sh,
                                         input logic rl);
        int    sum [N_LANES];
        int    v;
        word_t act;
        word_t row;
        word_t res;
        for (int j = 0; j < N_LANES; j++) begin
            sum[j] = 0;
        end
        for (int k = 0; k <= int'(ntm1); k++) begin
            act = shadow[a + addr_t'(k)];
            for (int j = 0; j < N_LANES; j++) begin
                row = shadow[w + addr_t'(N_LANES * k + j)];
                for (int i = 0; i < N_LANES; i++) begin
                    sum[j] += int'($signed(act[ELEM_W*i +: ELEM_W]))
                            * int'($signed(row[ELEM_W*i +: ELEM_W]));
                end
            end
        end
        for (int j = 0; j < N_LANES; j++) begin
            v = sum[j] >>> sh;
            if (rl && v < 0) begin
                v = 0;
            end
            if (v > 127) begin
                v = 127;
            end else if (v < -128) begin
                v = -128;
            end
            res[ELEM_W*j +: ELEM_W] = v[ELEM_W-1:0];
        end
        return res;
    endfunction

    task automatic start_job(input addr_t a, input addr_t w, input addr_t q,
                             input tiles_m1_t ntm1, input shift_t sh, input logic rl);
        start      = 1'b1;
        a_addr     = a;
        w_addr     = w;
        q_addr     = q;
        n_tiles_m1 = ntm1;
        shift      = sh;
        relu       = rl;
        step();
        start = 1'b0;
    endtask

    task automatic run_and_check(input addr_t a, input addr_t w, input addr_t q,
                                 input tiles_m1_t ntm1, input shift_t sh, input logic rl);
        word_t exp;
        exp = gemv_model(a, w, ntm1, sh, rl);
        wait_for("idle");
        start_job(a, w, q, ntm1, sh, rl);
        wait_for("done");
        shadow[q] = exp;
        check_read(q);
    endtask

    // ======================================================================
    // directed tests
    // ======================================================================
    task automatic test_reset_state();
        addr_t addrs [32];
        check("busy", 32'(busy), 32'd0);
        check("done", 32'(done), 32'd0);
        check("host_rvalid", 32'(host_rvalid), 32'd0);
        check("host_ready", 32'(host_ready), 32'd1);
        for (int i = 0; i < 32; i++) begin
            addrs[i] = addr_t'(rand_bits(8));
            host_write(addrs[i], rand_bits(32));
        end
        for (int i = 0; i < 32; i++) begin
            check_read(addrs[i]);
        end
    endtask

    task automatic test_single_tile();
        load_job(8'h10, 8'h20, 4'd0, 0);
        run_and_check(8'h10, 8'h20, 8'h30, 4'd0, 4'd0, 1'b0);
    endtask

    task automatic test_random_jobs();
        addr_t     base;
        tiles_m1_t ntm1;
        shift_t    sh;
        logic      rl;
        int        kind;
        for (int t = 0; t < 6; t++) begin
            base = addr_t'(rand_bits(8));
            ntm1 = tiles_m1_t'(rand_bits(4));
            rl   = 1'(rand_bits(1));
            kind = (t % 2 == 0) ? 2 : 1;
            sh   = (kind == 2) ? shift_t'(rand_bits(2)) : shift_t'(rand_bits(4));
            // first job pushes every lane well past int8
            if (t == 0) begin
                ntm1 = 4'd15;
                sh   = 4'd0;
                rl   = 1'b0;
            end
            load_job(base, base + 8'd16, ntm1, kind);
            run_and_check(base, base + 8'd16, base + 8'd80, ntm1, sh, rl);
        end
    endtask

    task automatic test_host_under_load();
        addr_t base;
        addr_t scr;
        word_t exp;
        base = addr_t'(rand_bits(8));
        scr  = base + 8'd96;
        load_job(base, base + 8'd16, 4'd15, 1);
        exp = gemv_model(base, base + 8'd16, 4'd15, 4'd6, 1'b0);
        wait_for("idle");
        fork
            begin
                start_job(base, base + 8'd16, base + 8'd80, 4'd15, 4'd6, 1'b0);
                wait_for("done");
            end
            begin
                wait_for("busy");
                // read held behind the fetch reads
                check_read(base);
                for (int i = 0; i < 4; i++) begin
                    host_write(scr + addr_t'(i), rand_bits(32));
                end
                for (int i = 0; i < 4; i++) begin
                    check_read(scr + addr_t'(i));
                end
            end
        join
        shadow[base + 8'd80] = exp;
        check_read(base + 8'd80);
    endtask

    task automatic test_start_while_busy();
        addr_t base;
        addr_t q2;
        word_t exp;
        int    dones;
        base = addr_t'(rand_bits(8));
        q2   = base + 8'd120;
        load_job(base, base + 8'd16, 4'd3, 1);
        host_write(q2, rand_bits(32));
        exp = gemv_model(base, base + 8'd16, 4'd3, 4'd2, 1'b1);
        wait_for("idle");
        dones = done_count;
        start_job(base, base + 8'd16, base + 8'd80, 4'd3, 4'd2, 1'b1);
        repeat (3) step();
        check("busy", 32'(busy), 32'd1);
        // second job must be dropped
        start_job(base + 8'd40, base + 8'd16, q2, 4'd0, 4'd0, 1'b0);
        wait_for("done");
        repeat (20) step();
        check("done pulses", 32'(done_count - dones), 32'd1);
        check("busy", 32'(busy), 32'd0);
        shadow[base + 8'd80] = exp;
        check_read(base + 8'd80);
        check_read(q2);
    endtask

    initial begin
        lfsr_state = 32'h7d91_be64;
        done_count = 0;
        host_wr    = 1'b0;
        host_rd    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        start      = 1'b0;
        a_addr     = '0;
        w_addr     = '0;
        q_addr     = '0;
        n_tiles_m1 = '0;
        shift      = '0;
        relu       = 1'b0;
        repeat (10) step();

        test_reset_state();
        test_single_tile();
        test_random_jobs();
        test_host_under_load();
        test_start_while_busy();

        $display("Everything OK");
        $finish;
    end

endmodule

//--- bench/gemv_sva.sv
/*
 * GEMV engine assertions, bound into gemv_top
 * job done and busy timing, host read return rules
 */
`timescale 1ns/10ps

module gemv_sva (
    input logic clk,
    input logic rst_n,
    input logic done,
    input logic busy,
    input logic host_rd,
    input logic host_ready,
    input logic host_rvalid
);
    // host read accepted, return still outstanding
    logic rd_open;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_open <= 1'b0;
        end else if (host_rd && host_ready) begin
            rd_open <= 1'b1;
        end else if (host_rvalid) begin
            rd_open <= 1'b0;
        end
    end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done held high for more than one cycle");

    busy_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        (done || $fell(busy)) |-> (done && $fell(busy)))
        else $error("busy and done are out of step");

    rvalid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        host_rvalid |-> rd_open)
        else $error("host_rvalid without an accepted read");

    ready_with_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        host_rvalid |-> host_ready)
        else $error("host_ready low during host_rvalid");

endmodule

bind gemv_top gemv_sva gemv_sva_u (
    .clk, .rst_n, .done, .busy, .host_rd, .host_ready, .host_rvalid
);

//--- rtl/gemv_top.sv
/*
 * GEMV tile engine top level
 * layerio memory shared by host port, tile fetcher and writeback
 */
`timescale 1ns/10ps

module gemv_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      host_wr,
    input  logic                      host_rd,
    input  layerio_mem_pkg::addr_t    host_addr,
    input  layerio_mem_pkg::word_t    host_wdata,
    output logic                      host_ready,
    output layerio_mem_pkg::word_t    host_rdata,
    output logic                      host_rvalid,
    input  logic                      start,
    input  layerio_mem_pkg::addr_t    a_addr,
    input  layerio_mem_pkg::addr_t    w_addr,
    input  layerio_mem_pkg::addr_t    q_addr,
    input  gemv_arith_pkg::tiles_m1_t n_tiles_m1,
    input  gemv_arith_pkg::shift_t    shift,
    input  logic                      relu,
    output logic                      busy,
    output logic                      done
);
    import gemv_arith_pkg::*;
    import layerio_mem_pkg::*;

    logic                      mem_en;
    logic                      mem_we;
    addr_t                     mem_addr;
    word_t                     mem_wdata;
    word_t                     mem_rdata;
    acc_t [N_LANES-1:0]        acc;
    logic                      acc_ready;
    logic                      job_start;

    mem_req_if  wb_req ();
    mem_req_if  fetch_req ();
    mem_req_if  host_req ();
    mac_feed_if feed ();

    // start is dropped while a job runs
    assign job_start = start && !busy;

    // ======================================================================
    // memory and arbitration
    // ======================================================================
    layerio_mem layerio_mem_u (
        .clk, .en(mem_en), .we(mem_we), .addr(mem_addr),
        .wdata(mem_wdata), .rdata(mem_rdata)
    );

    mem_arbiter mem_arbiter_u (
        .clk, .rst_n, .wb(wb_req), .fetch(fetch_req), .host(host_req),
        .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

    host_port host_port_u (
        .clk, .rst_n, .host_wr, .host_rd, .host_addr, .host_wdata,
        .host_ready, .host_rvalid, .host_rdata, .mem(host_req)
    );

    // ======================================================================
    // arithmetic path
    // ======================================================================
    tile_fetch tile_fetch_u (
        .clk, .rst_n, .start(job_start), .a_addr, .w_addr, .n_tiles_m1,
        .busy, .job_done(done), .mem(fetch_req), .feed(feed.source)
    );

    mxu mxu_u (
        .clk, .rst_n, .feed(feed.sink), .acc, .acc_ready
    );

    quant_writeback quant_writeback_u (
        .clk, .rst_n, .start(job_start), .q_addr, .shift, .relu,
        .acc, .acc_ready, .mem(wb_req), .done
    );

endmodule

//--- rtl/quant_writeback.sv
/*
 * quantize and writeback
 * shift, optional ReLU, int8 saturation, result word write, job done
 */
`timescale 1ns/10ps

module quant_writeback (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              start,
    input  layerio_mem_pkg::addr_t                            q_addr,
    input  gemv_arith_pkg::shift_t                            shift,
    input  logic                                              relu,
    input  gemv_arith_pkg::acc_t [gemv_arith_pkg::N_LANES-1:0] acc,
    input  logic                                              acc_ready,
    mem_req_if.requester                                      mem,
    output logic                                              done
);
    import gemv_arith_pkg::*;

    localparam acc_t Q_MAX = acc_t'((1 << (ELEM_W - 1)) - 1);
    localparam acc_t Q_MIN = -Q_MAX - acc_t'(1);

    shift_t shift_r;
    logic   relu_r;
    vec_t   q_vec;

    function automatic elem_t quantize(acc_t a, shift_t sh, logic relu_en);
        acc_t v;
        v = a >>> sh;
        if (relu_en && v < 0) begin
            v = '0;
        end
        if (v > Q_MAX) begin
            v = Q_MAX;
        end else if (v < Q_MIN) begin
            v = Q_MIN;
        end
        return v[ELEM_W-1:0];
    endfunction

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            q_vec[i*ELEM_W +: ELEM_W] = quantize(acc[i], shift_r, relu_r);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem.addr <= q_addr;
            shift_r  <= shift;
            relu_r   <= relu;
        end
        if (acc_ready) begin
            mem.wdata <= q_vec;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem.req <= 1'b0;
        end else if (acc_ready) begin
            mem.req <= 1'b1;
        end else if (mem.gnt) begin
            mem.req <= 1'b0;
        end
    end

    assign mem.we = 1'b1;
    assign done   = mem.req && mem.gnt;

endmodule

//--- rtl/mxu.sv
/*
 * MXU
 * activation register and four signed multiply-accumulate lanes
 */
`timescale 1ns/10ps

module mxu (
    input  logic                                               clk,
    input  logic                                               rst_n,
    mac_feed_if.sink                                           feed,
    output gemv_arith_pkg::acc_t [gemv_arith_pkg::N_LANES-1:0] acc,
    output logic                                               acc_ready
);
    import gemv_arith_pkg::*;

    vec_t  act;
    elem_t a_e;
    elem_t w_e;
    acc_t  dot;
    logic  last_q;

    // four-term dot product of the row against the activation
    always_comb begin
        dot = '0;
        for (int i = 0; i < N_LANES; i++) begin
            a_e = act[i*ELEM_W +: ELEM_W];
            w_e = feed.data[i*ELEM_W +: ELEM_W];
            dot = dot + a_e * w_e;
        end
    end

    always_ff @(posedge clk) begin
        if (feed.act_valid) begin
            act <= feed.data;
        end
        if (feed.clear) begin
            acc <= '0;
        end else if (feed.wt_valid) begin
            acc[feed.lane] <= acc[feed.lane] + dot;
        end
    end

    // ready one cycle after the final update lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q    <= 1'b0;
            acc_ready <= 1'b0;
        end else begin
            last_q    <= feed.wt_valid && feed.last;
            acc_ready <= last_q;
        end
    end

endmodule

//--- rtl/tile_fetch.sv
/*
 * tile fetcher
 * issues activation and weight-row reads per tile, feeds returns to the MXU
 */
`timescale 1ns/10ps

module tile_fetch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  layerio_mem_pkg::addr_t    a_addr,
    input  layerio_mem_pkg::addr_t    w_addr,
    input  gemv_arith_pkg::tiles_m1_t n_tiles_m1,
    output logic                      busy,
    input  logic                      job_done,
    mem_req_if.requester              mem,
    mac_feed_if.source                feed
);
    import gemv_arith_pkg::*;
    import layerio_mem_pkg::*;

    // slot 0 is the activation, slots 1..N_LANES the weight rows
    localparam int SLOT_W = $clog2(N_LANES + 1);

    typedef logic [SLOT_W-1:0] slot_t;
    typedef enum logic [1:0] {IDLE, ISSUE, DRAIN, WAIT_WB} state_e;

    state_e    state;
    tiles_m1_t n_m1;
    tiles_m1_t iss_tile;
    tiles_m1_t ret_tile;
    slot_t     iss_slot;
    slot_t     ret_slot;
    addr_t     a_ptr;
    addr_t     w_ptr;
    logic      iss_end;
    logic      ret_end;
    logic      fire;

    assign fire    = mem.req && mem.gnt;
    assign iss_end = (iss_slot == slot_t'(N_LANES)) && (iss_tile == n_m1);
    assign ret_end = (ret_slot == slot_t'(N_LANES)) && (ret_tile == n_m1);

    // ======================================================================
    // read issue
    // ======================================================================
    assign mem.req   = (state == ISSUE);
    assign mem.we    = 1'b0;
    assign mem.addr  = (iss_slot == '0) ? a_ptr : w_ptr;
    assign mem.wdata = '0;

    // ======================================================================
    // return steering, in issue order
    // ======================================================================
    assign feed.act_valid = mem.rvalid && (ret_slot == '0);
    assign feed.wt_valid  = mem.rvalid && (ret_slot != '0);
    assign feed.lane      = lane_t'(ret_slot - slot_t'(1));
    assign feed.data      = mem.rdata;
    assign feed.last      = mem.rvalid && ret_end;

    // drops with the writeback done pulse
    assign busy = (state != IDLE) && !((state == WAIT_WB) && job_done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            feed.clear <= 1'b0;
            iss_tile   <= '0;
            iss_slot   <= '0;
            ret_tile   <= '0;
            ret_slot   <= '0;
        end else begin
            feed.clear <= start;
            if (start) begin
                state    <= ISSUE;
                iss_tile <= '0;
                iss_slot <= '0;
                ret_tile <= '0;
                ret_slot <= '0;
            end else begin
                case (state)
                    ISSUE:   if (fire && iss_end) state <= DRAIN;
                    DRAIN:   if (feed.last) state <= WAIT_WB;
                    WAIT_WB: if (job_done) state <= IDLE;
                    default: state <= IDLE;
                endcase
                if (fire) begin
                    if (iss_slot == slot_t'(N_LANES)) begin
                        iss_slot <= '0;
                        iss_tile <= iss_tile + 1'b1;
                    end else begin
                        iss_slot <= iss_slot + 1'b1;
                    end
                end
                if (mem.rvalid) begin
                    if (ret_slot == slot_t'(N_LANES)) begin
                        ret_slot <= '0;
                        ret_tile <= ret_tile + 1'b1;
                    end else begin
                        ret_slot <= ret_slot + 1'b1;
                    end
                end
            end
        end
    end

    // job registers and address pointers
    always_ff @(posedge clk) begin
        if (start) begin
            n_m1  <= n_tiles_m1;
            a_ptr <= a_addr;
            w_ptr <= w_addr;
        end else if (fire) begin
            if (iss_slot == '0) begin
                a_ptr <= a_ptr + 1'b1;
            end else begin
                w_ptr <= w_ptr + 1'b1;
            end
        end
    end

endmodule

//--- rtl/host_port.sv
/*
 * host port
 * one outstanding host access held as a memory request
 */
`timescale 1ns/10ps

module host_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   host_wr,
    input  logic                   host_rd,
    input  layerio_mem_pkg::addr_t host_addr,
    input  layerio_mem_pkg::word_t host_wdata,
    output logic                   host_ready,
    output logic                   host_rvalid,
    output layerio_mem_pkg::word_t host_rdata,
    mem_req_if.requester           mem
);
    logic accept;

    assign accept = host_ready && (host_wr || host_rd);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem.req     <= 1'b0;
            host_ready  <= 1'b1;
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= mem.rvalid;
            if (accept) begin
                mem.req    <= 1'b1;
                host_ready <= 1'b0;
            end else if (mem.req && mem.gnt) begin
                mem.req <= 1'b0;
                // a write is finished at the grant
                if (mem.we) begin
                    host_ready <= 1'b1;
                end
            end
            if (mem.rvalid) begin
                host_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem.we    <= host_wr;
            mem.addr  <= host_addr;
            mem.wdata <= host_wdata;
        end
        if (mem.rvalid) begin
            host_rdata <= mem.rdata;
        end
    end

endmodule

//--- rtl/mem_arbiter.sv
/*
 * layerio memory arbiter
 * fixed priority writeback, fetch, host; routes read returns
 */
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    mem_req_if.arbiter             wb,
    mem_req_if.arbiter             fetch,
    mem_req_if.arbiter             host,
    output logic                   mem_en,
    output logic                   mem_we,
    output layerio_mem_pkg::addr_t mem_addr,
    output layerio_mem_pkg::word_t mem_wdata,
    input  layerio_mem_pkg::word_t mem_rdata
);
    import layerio_mem_pkg::*;

    req_id_e sel;
    req_id_e rd_owner;
    logic    rd_pend;

    always_comb begin
        if (wb.req) begin
            sel = REQ_WB;
        end else if (fetch.req) begin
            sel = REQ_FETCH;
        end else begin
            sel = REQ_HOST;
        end
    end

    assign mem_en = wb.req || fetch.req || host.req;

    always_comb begin
        case (sel)
            REQ_WB: begin
                mem_we    = wb.we;
                mem_addr  = wb.addr;
                mem_wdata = wb.wdata;
            end
            REQ_FETCH: begin
                mem_we    = fetch.we;
                mem_addr  = fetch.addr;
                mem_wdata = fetch.wdata;
            end
            default: begin
                mem_we    = host.we;
                mem_addr  = host.addr;
                mem_wdata = host.wdata;
            end
        endcase
    end

    assign wb.gnt    = mem_en && (sel == REQ_WB);
    assign fetch.gnt = mem_en && (sel == REQ_FETCH);
    assign host.gnt  = mem_en && (sel == REQ_HOST);

    // who owns the read data next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend  <= 1'b0;
            rd_owner <= REQ_WB;
        end else begin
            rd_pend  <= mem_en && !mem_we;
            rd_owner <= sel;
        end
    end

    assign wb.rvalid    = rd_pend && (rd_owner == REQ_WB);
    assign fetch.rvalid = rd_pend && (rd_owner == REQ_FETCH);
    assign host.rvalid  = rd_pend && (rd_owner == REQ_HOST);

    // data goes to all, rvalid says whose it is
    assign wb.rdata    = mem_rdata;
    assign fetch.rdata = mem_rdata;
    assign host.rdata  = mem_rdata;

endmodule

//--- rtl/layerio_mem.sv
/*
 * layerio memory
 * single-port synchronous RAM, read data one cycle after the address
 */
`timescale 1ns/10ps

module layerio_mem (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  layerio_mem_pkg::addr_t addr,
    input  layerio_mem_pkg::word_t wdata,
    output layerio_mem_pkg::word_t rdata
);
    import layerio_mem_pkg::*;

    word_t ram [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                ram[addr] <= wdata;
            end else begin
                rdata <= ram[addr];
            end
        end
    end

endmodule

//--- rtl/accel_ifs.sv
/*
 * memory request interface and MXU feed interface
 */
`timescale 1ns/10ps

// ======================================================================
// memory request, held by the requester until gnt
// ======================================================================
interface mem_req_if;
    import layerio_mem_pkg::*;

    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    logic  gnt;
    // read return, one cycle after gnt
    logic  rvalid;
    word_t rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );
endinterface

// ======================================================================
// fetcher to MXU stream
// ======================================================================
interface mac_feed_if;
    import gemv_arith_pkg::*;

    logic  clear;
    logic  act_valid;
    logic  wt_valid;
    lane_t lane;
    vec_t  data;
    logic  last;

    modport source (output clear, act_valid, wt_valid, lane, data, last);
    modport sink   (input  clear, act_valid, wt_valid, lane, data, last);
endinterface

//--- rtl/layerio_mem_pkg.sv
/*
 * layerio memory definitions
 * depth, address and word types, requester index
 */
package layerio_mem_pkg;

    localparam int MEM_DEPTH = 256;
    localparam int ADDR_W    = $clog2(MEM_DEPTH);
    localparam int WORD_W    = 32;

    // addresses wrap modulo MEM_DEPTH
    typedef logic [ADDR_W-1:0] addr_t;

    // one word holds one packed lane vector
    typedef logic [WORD_W-1:0] word_t;

    // requester index, also the arbiter priority order
    typedef enum logic [1:0] {
        REQ_WB,
        REQ_FETCH,
        REQ_HOST
    } req_id_e;

endpackage

//--- rtl/gemv_arith_pkg.sv
/*
 * GEMV arithmetic definitions
 * lane count, element and accumulator widths, vector and control types
 */
package gemv_arith_pkg;

    localparam int N_LANES = 4;
    localparam int ELEM_W  = 8;
    localparam int ACC_W   = 24;

    // lane index on the MXU feed
    localparam int LANE_W = $clog2(N_LANES);

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // lane i sits in bits 8i..8i+7
    typedef logic [N_LANES*ELEM_W-1:0] vec_t;

    typedef logic [LANE_W-1:0] lane_t;
    typedef logic [3:0]        shift_t;
    typedef logic [3:0]        tiles_m1_t;

endpackage
